// File: bench/riscv_core_tb.sv
`include "rv_consts.svh"

module riscv_core_tb;

  typedef struct {
    string             name;
    rv_pkg::word_t     insn;
    rv_pkg::word_t     load_data;
    rv_pkg::word_t     pc;
    rv_pkg::dmem_req_t dmem;
    logic              halt;
  } row_t;

  localparam rv_pkg::word_t nop_insn = 32'h0000_0013;
  localparam rv_pkg::word_t load_pattern = 32'h80f1_7f82;

  localparam rv_pkg::reg_addr_t x0 = 5'd0;
  localparam rv_pkg::reg_addr_t x1 = 5'd1;
  localparam rv_pkg::reg_addr_t x2 = 5'd2;
  localparam rv_pkg::reg_addr_t x3 = 5'd3;
  localparam rv_pkg::reg_addr_t x4 = 5'd4;
  localparam rv_pkg::reg_addr_t x5 = 5'd5;
  localparam rv_pkg::reg_addr_t x7 = 5'd7;
  localparam rv_pkg::reg_addr_t x8 = 5'd8;
  localparam rv_pkg::reg_addr_t x9 = 5'd9;

  logic              clk = 1'b0;
  logic              rst_i;
  rv_pkg::word_t     insn_i;
  rv_pkg::word_t     load_data_i;
  rv_pkg::word_t     pc_o;
  rv_pkg::dmem_req_t dmem_o;
  logic              halt_o;

  row_t          rows[$];
  rv_pkg::word_t cur_pc;
  rv_pkg::word_t store_slot;
  integer        seed = 32'he73e;
  int            cycles = 0;
  int            cycle_limit = 0;

  riscv_core riscv_core_i (
    .clk_i       (clk),
    .rst_i       (rst_i),
    .insn_i      (insn_i),
    .load_data_i (load_data_i),
    .pc_o        (pc_o),
    .dmem_o      (dmem_o),
    .halt_o      (halt_o)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      abort_run("simulation hung: cycle limit reached before the table finished");
    end
  end

  task automatic check_word(input string name, input rv_pkg::word_t exp,
                            input rv_pkg::word_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_dmem(input string name, input rv_pkg::dmem_req_t exp,
                            input rv_pkg::dmem_req_t act);
    rv_pkg::dmem_req_t want;
    want = exp;
    // without a write the address is just the alu result
    if (exp.byte_en == '0) begin
      want.addr = act.addr;
    end
    if (act !== want) begin
      abort_run($sformatf(
        "CHECK FAILED %s: expected addr=%h wdata=%h be=%b, actual addr=%h wdata=%h be=%b",
        name, want.addr, want.wdata, want.byte_en, act.addr, act.wdata, act.byte_en));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s halt: expected %b, actual %b", name, exp, act));
    end
  endtask

  // instruction encoders, one per format
  function automatic rv_pkg::word_t encode_i(input logic [11:0] imm,
                                             input rv_pkg::reg_addr_t rs1,
                                             input logic [2:0] f3,
                                             input rv_pkg::reg_addr_t rd,
                                             input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t encode_s(input logic [11:0] imm,
                                             input rv_pkg::reg_addr_t rs2,
                                             input rv_pkg::reg_addr_t rs1,
                                             input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic rv_pkg::word_t encode_r(input logic [6:0] f7, input logic [2:0] f3);
    // always x3 = x1 op x2
    return {f7, x2, x1, f3, x3, `RV_OP_REG};
  endfunction

  function automatic rv_pkg::word_t encode_b(input logic [12:0] imm,
                                             input rv_pkg::reg_addr_t rs2,
                                             input rv_pkg::reg_addr_t rs1,
                                             input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t encode_j(input logic [20:0] imm,
                                             input rv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  function automatic rv_pkg::dmem_req_t make_dmem(input rv_pkg::word_t addr,
                                                  input rv_pkg::word_t wdata,
                                                  input rv_pkg::byte_en_t be);
    return {addr, wdata, be};
  endfunction

  // two's complement order: a negative value is below any non-negative one
  function automatic logic signed_less(input rv_pkg::word_t v1, input rv_pkg::word_t v2);
    if (v1[31] != v2[31]) begin
      return v1[31];
    end
    return v1 < v2;
  endfunction

  function automatic rv_pkg::word_t shift_right_arith(input rv_pkg::word_t v,
                                                      input logic [4:0] s);
    rv_pkg::word_t fill;
    // vacated upper bits take copies of the sign
    fill = v[31] ? ~(32'hffff_ffff >> s) : 32'd0;
    return (v >> s) | fill;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t v1,
                                        input rv_pkg::word_t v2);
    case (f3)
      `RV_F3_BEQ:  return v1 == v2;
      `RV_F3_BNE:  return v1 != v2;
      `RV_F3_BLT:  return signed_less(v1, v2);
      `RV_F3_BGE:  return !signed_less(v1, v2);
      `RV_F3_BLTU: return v1 < v2;
      `RV_F3_BGEU: return !(v1 < v2);
      default:     return 1'b0;
    endcase
  endfunction

  task automatic add_row(input string name, input rv_pkg::word_t insn,
                         input rv_pkg::word_t ld, input rv_pkg::dmem_req_t dmem,
                         input logic halt);
    row_t r;
    r.name      = name;
    r.insn      = insn;
    r.load_data = ld;
    r.pc        = cur_pc;
    r.dmem      = dmem;
    r.halt      = halt;
    rows.push_back(r);
    cur_pc = cur_pc + 32'd4;
  endtask

  task automatic plain_row(input string name, input rv_pkg::word_t insn);
    add_row(name, insn, '0, '0, 1'b0);
  endtask

  // a register is observed by storing it to the next free word
  task automatic store_check(input string name, input rv_pkg::reg_addr_t rs,
                             input rv_pkg::word_t exp);
    add_row({name, " sw"}, encode_s(store_slot[11:0], rs, x0, `RV_F3_SW), '0,
            make_dmem(store_slot, exp, 4'b1111), 1'b0);
    store_slot = store_slot + 32'd4;
  endtask

  task automatic load_const(input rv_pkg::reg_addr_t rd, input rv_pkg::word_t value);
    rv_pkg::word_t rounded;
    // addi sign-extends, so round the upper part
    rounded = value + 32'h800;
    plain_row("lui", {rounded[31:12], rd, `RV_OP_LUI});
    plain_row("addi", encode_i(value[11:0], rd, `RV_F3_ADD, rd, `RV_OP_IMM));
  endtask

  task automatic load_check(input string name, input logic [2:0] f3, input logic [1:0] off,
                            input rv_pkg::word_t exp);
    add_row(name, encode_i(12'h300 + {10'd0, off}, x0, f3, x7, `RV_OP_LOAD),
            load_pattern, '0, 1'b0);
    store_check(name, x7, exp);
  endtask

  task automatic branch_check(input string name, input logic [2:0] f3,
                              input rv_pkg::reg_addr_t rs1, input rv_pkg::reg_addr_t rs2,
                              input rv_pkg::word_t v1, input rv_pkg::word_t v2);
    rv_pkg::word_t here;
    here = cur_pc;
    plain_row(name, encode_b(13'd16, rs2, rs1, f3));
    if (branch_taken(f3, v1, v2)) begin
      cur_pc = here + 32'd16;
    end
  endtask

  task automatic fill_table(input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t here;
    rv_pkg::word_t link;
    logic [1:0]    off;
    plain_row("nop 0", nop_insn);
    plain_row("nop 1", nop_insn);
    load_const(x1, a);
    load_const(x2, b);
    store_check("const a", x1, a);
    store_check("const b", x2, b);

    plain_row("add", encode_r(`RV_F7_BASE, `RV_F3_ADD));
    store_check("add", x3, a + b);
    plain_row("sub", encode_r(`RV_F7_ALT, `RV_F3_ADD));
    store_check("sub", x3, a - b);
    plain_row("xor", encode_r(`RV_F7_BASE, `RV_F3_XOR));
    store_check("xor", x3, a ^ b);
    plain_row("or", encode_r(`RV_F7_BASE, `RV_F3_OR));
    store_check("or", x3, a | b);
    plain_row("and", encode_r(`RV_F7_BASE, `RV_F3_AND));
    store_check("and", x3, a & b);
    plain_row("sll", encode_r(`RV_F7_BASE, `RV_F3_SLL));
    store_check("sll", x3, a << b[4:0]);
    plain_row("srl", encode_r(`RV_F7_BASE, `RV_F3_SRL));
    store_check("srl", x3, a >> b[4:0]);
    plain_row("sra", encode_r(`RV_F7_ALT, `RV_F3_SRL));
    store_check("sra", x3, shift_right_arith(a, b[4:0]));
    plain_row("slt", encode_r(`RV_F7_BASE, `RV_F3_SLT));
    store_check("slt", x3, {31'd0, signed_less(a, b)});
    plain_row("sltu", encode_r(`RV_F7_BASE, `RV_F3_SLTU));
    store_check("sltu", x3, {31'd0, a < b});

    plain_row("addi neg", encode_i(12'hffb, x1, `RV_F3_ADD, x4, `RV_OP_IMM));
    store_check("addi neg", x4, a - 32'd5);
    plain_row("srai", encode_i({`RV_F7_ALT, 5'd7}, x1, `RV_F3_SRL, x4, `RV_OP_IMM));
    store_check("srai", x4, shift_right_arith(a, 5'd7));
    plain_row("sltiu", encode_i(12'hfff, x2, `RV_F3_SLTU, x4, `RV_OP_IMM));
    store_check("sltiu", x4, {31'd0, b < 32'hffff_ffff});
    plain_row("lui", {20'habcde, x5, `RV_OP_LUI});
    store_check("lui", x5, 32'habcd_e000);
    here = cur_pc;
    plain_row("auipc", {20'h12345, x5, `RV_OP_AUIPC});
    store_check("auipc", x5, here + 32'h1234_5000);

    for (int k = 0; k < 4; k++) begin
      off = k[1:0];
      add_row($sformatf("sb offset %0d", k), encode_s(12'h200 + {10'd0, off}, x2, x0, `RV_F3_SB),
              '0, make_dmem(32'h200, {4{b[7:0]}}, 4'b0001 << off), 1'b0);
    end
    add_row("sh offset 0", encode_s(12'h280, x2, x0, `RV_F3_SH), '0,
            make_dmem(32'h280, {2{b[15:0]}}, 4'b0011), 1'b0);
    add_row("sh offset 2", encode_s(12'h282, x2, x0, `RV_F3_SH), '0,
            make_dmem(32'h280, {2{b[15:0]}}, 4'b1100), 1'b0);

    load_check("lb offset 0", `RV_F3_LB, 2'd0, 32'hffff_ff82);
    load_check("lbu offset 0", `RV_F3_LBU, 2'd0, 32'h0000_0082);
    load_check("lb offset 1", `RV_F3_LB, 2'd1, 32'h0000_007f);
    load_check("lb offset 2", `RV_F3_LB, 2'd2, 32'hffff_fff1);
    load_check("lbu offset 3", `RV_F3_LBU, 2'd3, 32'h0000_0080);
    load_check("lh offset 0", `RV_F3_LH, 2'd0, 32'h0000_7f82);
    load_check("lh offset 2", `RV_F3_LH, 2'd2, 32'hffff_80f1);
    load_check("lhu offset 2", `RV_F3_LHU, 2'd2, 32'h0000_80f1);
    load_check("lw", `RV_F3_LW, 2'd0, 32'h80f1_7f82);

    // each kind once taken and once not, unless the random operands are equal
    branch_check("beq same", `RV_F3_BEQ, x1, x1, a, a);
    branch_check("beq diff", `RV_F3_BEQ, x1, x2, a, b);
    branch_check("bne same", `RV_F3_BNE, x1, x1, a, a);
    branch_check("bne diff", `RV_F3_BNE, x1, x2, a, b);
    branch_check("blt ab", `RV_F3_BLT, x1, x2, a, b);
    branch_check("blt ba", `RV_F3_BLT, x2, x1, b, a);
    branch_check("bge ab", `RV_F3_BGE, x1, x2, a, b);
    branch_check("bge ba", `RV_F3_BGE, x2, x1, b, a);
    branch_check("bltu ab", `RV_F3_BLTU, x1, x2, a, b);
    branch_check("bltu ba", `RV_F3_BLTU, x2, x1, b, a);
    branch_check("bgeu ab", `RV_F3_BGEU, x1, x2, a, b);
    branch_check("bgeu ba", `RV_F3_BGEU, x2, x1, b, a);

    here = cur_pc;
    link = here + 32'd4;
    plain_row("jal", encode_j(21'd24, x8));
    cur_pc = here + 32'd24;
    store_check("jal link", x8, link);
    here = cur_pc;
    plain_row("jalr", encode_i(12'd7, x8, 3'b000, x9, `RV_OP_JALR));
    cur_pc = (link + 32'd7) & 32'hffff_fffe;
    store_check("jalr link", x9, here + 32'd4);

    plain_row("write x0", encode_i(12'd0, x1, `RV_F3_ADD, x0, `RV_OP_IMM));
    store_check("x0", x0, 32'd0);
    add_row("ecall", 32'h0000_0073, '0, '0, 1'b1);
    plain_row("nop after ecall", nop_insn);
  endtask

  initial begin
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    rst_i       = 1'b1;
    insn_i      = nop_insn;
    load_data_i = '0;
    cur_pc      = '0;
    store_slot  = 32'h100;
    op_a        = $random(seed);
    op_b        = $random(seed);
    fill_table(op_a, op_b);
    cycle_limit = 16 + rows.size() + 20;

    repeat (16) @(posedge clk);
    #2;
    rst_i = 1'b0;

    foreach (rows[i]) begin
      check_word({rows[i].name, " pc"}, rows[i].pc, pc_o);
      insn_i      = rows[i].insn;
      load_data_i = rows[i].load_data;
      @(negedge clk);
      check_dmem(rows[i].name, rows[i].dmem, dmem_o);
      check_bit(rows[i].name, rows[i].halt, halt_o);
      @(posedge clk);
      #2;
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: hw/riscv_core.sv
`include "rv_consts.svh"

module riscv_core (
  input  logic              clk_i,
  input  logic              rst_i,
  input  rv_pkg::word_t     insn_i,
  input  rv_pkg::word_t     load_data_i,
  output rv_pkg::word_t     pc_o,
  output rv_pkg::dmem_req_t dmem_o,
  output logic              halt_o
);

  rv_pkg::ctrl_t ctrl;
  rv_pkg::word_t rs1_data;
  rv_pkg::word_t rs2_data;
  rv_pkg::word_t alu_a;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_result;
  rv_pkg::word_t load_result;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t wb_data;
  logic          reg_we;

  rv_decoder rv_decoder_i (
    .insn_i (insn_i),
    .ctrl_o (ctrl)
  );

  // no register write while reset is held
  assign reg_we = ctrl.reg_write && !rst_i;

  rv_regfile rv_regfile_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_i      (ctrl.rs1),
    .rs2_i      (ctrl.rs2),
    .rd_i       (ctrl.rd),
    .we_i       (reg_we),
    .rd_data_i  (wb_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // auipc adds to the pc, immediates replace rs2
  assign alu_a = ctrl.src_a_pc ? pc_o : rs1_data;
  assign alu_b = ctrl.src_b_imm ? ctrl.imm : rs2_data;

  rv_alu rv_alu_i (
    .op_i     (ctrl.alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  rv_lsu rv_lsu_i (
    .ctrl_i        (ctrl),
    .addr_i        (alu_result),
    .store_data_i  (rs2_data),
    .load_data_i   (load_data_i),
    .dmem_o        (dmem_o),
    .load_result_o (load_result)
  );

  rv_pc_unit rv_pc_unit_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ctrl_i     (ctrl),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .pc_o       (pc_o),
    .pc_plus4_o (pc_plus4)
  );

  // writeback source, jumps link pc+4
  always_comb begin
    case (ctrl.wb_sel)
      `RV_WB_LOAD: wb_data = load_result;
      `RV_WB_PC4:  wb_data = pc_plus4;
      default:     wb_data = alu_result;
    endcase
  end

  assign halt_o = ctrl.halt;

endmodule

// File: hw/rv_alu.sv
`include "rv_consts.svh"

module rv_alu (
  input  rv_pkg::alu_op_t op_i,
  input  rv_pkg::word_t   a_i,
  input  rv_pkg::word_t   b_i,
  output rv_pkg::word_t   result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      `RV_ALU_ADD:    result_o = a_i + b_i;
      `RV_ALU_SUB:    result_o = a_i - b_i;
      `RV_ALU_SLL:    result_o = a_i << shamt;
      `RV_ALU_SLT:    result_o = rv_pkg::word_t'(lt_signed);
      `RV_ALU_SLTU:   result_o = rv_pkg::word_t'(lt_unsigned);
      `RV_ALU_XOR:    result_o = a_i ^ b_i;
      `RV_ALU_SRL:    result_o = a_i >> shamt;
      `RV_ALU_SRA:    result_o = rv_pkg::word_t'($signed(a_i) >>> shamt);
      `RV_ALU_OR:     result_o = a_i | b_i;
      `RV_ALU_AND:    result_o = a_i & b_i;
      // lui carries its upper immediate through
      `RV_ALU_PASS_B: result_o = b_i;
      default:        result_o = '0;
    endcase
  end

endmodule

// File: hw/rv_decoder.sv
`include "rv_consts.svh"

module rv_decoder (
  input  rv_pkg::word_t insn_i,
  output rv_pkg::ctrl_t ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_s;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t imm_u;

  assign opcode = insn_i[6:0];
  assign funct3 = insn_i[14:12];
  assign funct7 = insn_i[31:25];

  // sign-extended immediates for each format
  assign imm_i = {{20{insn_i[31]}}, insn_i[31:20]};
  assign imm_s = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};
  assign imm_b = {{19{insn_i[31]}}, insn_i[31], insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
  assign imm_j = {{11{insn_i[31]}}, insn_i[31], insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
  assign imm_u = {insn_i[31:12], 12'b0};

  always_comb begin
    ctrl_o               = '0;
    ctrl_o.rs1           = insn_i[19:15];
    ctrl_o.rs2           = insn_i[24:20];
    ctrl_o.rd            = insn_i[11:7];
    ctrl_o.branch_f3     = funct3;
    ctrl_o.alu_op        = `RV_ALU_ADD;
    ctrl_o.wb_sel        = `RV_WB_ALU;
    ctrl_o.mem_size      = `RV_MEM_WORD;
    ctrl_o.imm           = imm_i;

    case (opcode)
      `RV_OP_LUI: begin
        ctrl_o.imm       = imm_u;
        ctrl_o.alu_op    = `RV_ALU_PASS_B;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.reg_write = 1'b1;
      end
      `RV_OP_AUIPC: begin
        ctrl_o.imm       = imm_u;
        ctrl_o.src_a_pc  = 1'b1;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.reg_write = 1'b1;
      end
      `RV_OP_JAL: begin
        ctrl_o.imm       = imm_j;
        ctrl_o.is_jal    = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_sel    = `RV_WB_PC4;
      end
      `RV_OP_JALR: begin
        ctrl_o.is_jalr   = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_sel    = `RV_WB_PC4;
      end
      `RV_OP_BRANCH: begin
        ctrl_o.imm       = imm_b;
        ctrl_o.is_branch = 1'b1;
      end
      `RV_OP_LOAD: begin
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.wb_sel    = `RV_WB_LOAD;
        ctrl_o.is_load   = 1'b1;
        ctrl_o.reg_write = 1'b1;
        case (funct3)
          `RV_F3_LB:  ctrl_o.mem_size = `RV_MEM_BYTE;
          `RV_F3_LH:  ctrl_o.mem_size = `RV_MEM_HALF;
          `RV_F3_LW:  ctrl_o.mem_size = `RV_MEM_WORD;
          `RV_F3_LBU: begin
            ctrl_o.mem_size      = `RV_MEM_BYTE;
            ctrl_o.load_unsigned = 1'b1;
          end
          `RV_F3_LHU: begin
            ctrl_o.mem_size      = `RV_MEM_HALF;
            ctrl_o.load_unsigned = 1'b1;
          end
          default: begin
            ctrl_o.is_load   = 1'b0;
            ctrl_o.reg_write = 1'b0;
          end
        endcase
      end
      `RV_OP_STORE: begin
        ctrl_o.imm       = imm_s;
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.is_store  = 1'b1;
        case (funct3)
          `RV_F3_SB: ctrl_o.mem_size = `RV_MEM_BYTE;
          `RV_F3_SH: ctrl_o.mem_size = `RV_MEM_HALF;
          `RV_F3_SW: ctrl_o.mem_size = `RV_MEM_WORD;
          default:   ctrl_o.is_store = 1'b0;
        endcase
      end
      `RV_OP_IMM: begin
        ctrl_o.src_b_imm = 1'b1;
        ctrl_o.reg_write = 1'b1;
        case (funct3)
          `RV_F3_ADD:  ctrl_o.alu_op = `RV_ALU_ADD;
          `RV_F3_SLT:  ctrl_o.alu_op = `RV_ALU_SLT;
          `RV_F3_SLTU: ctrl_o.alu_op = `RV_ALU_SLTU;
          `RV_F3_XOR:  ctrl_o.alu_op = `RV_ALU_XOR;
          `RV_F3_OR:   ctrl_o.alu_op = `RV_ALU_OR;
          `RV_F3_AND:  ctrl_o.alu_op = `RV_ALU_AND;
          `RV_F3_SLL: begin
            ctrl_o.alu_op    = `RV_ALU_SLL;
            ctrl_o.reg_write = (funct7 == `RV_F7_BASE);
          end
          default: begin
            // srli or srai, picked by funct7
            ctrl_o.alu_op    = (funct7 == `RV_F7_ALT) ? `RV_ALU_SRA : `RV_ALU_SRL;
            ctrl_o.reg_write = (funct7 == `RV_F7_BASE) || (funct7 == `RV_F7_ALT);
          end
        endcase
      end
      `RV_OP_REG: begin
        if (funct7 == `RV_F7_BASE) begin
          ctrl_o.reg_write = 1'b1;
          case (funct3)
            `RV_F3_ADD:  ctrl_o.alu_op = `RV_ALU_ADD;
            `RV_F3_SLL:  ctrl_o.alu_op = `RV_ALU_SLL;
            `RV_F3_SLT:  ctrl_o.alu_op = `RV_ALU_SLT;
            `RV_F3_SLTU: ctrl_o.alu_op = `RV_ALU_SLTU;
            `RV_F3_XOR:  ctrl_o.alu_op = `RV_ALU_XOR;
            `RV_F3_SRL:  ctrl_o.alu_op = `RV_ALU_SRL;
            `RV_F3_OR:   ctrl_o.alu_op = `RV_ALU_OR;
            default:     ctrl_o.alu_op = `RV_ALU_AND;
          endcase
        end else if (funct7 == `RV_F7_ALT) begin
          // only sub and sra use the alternate funct7
          if (funct3 == `RV_F3_ADD) begin
            ctrl_o.alu_op    = `RV_ALU_SUB;
            ctrl_o.reg_write = 1'b1;
          end else if (funct3 == `RV_F3_SRL) begin
            ctrl_o.alu_op    = `RV_ALU_SRA;
            ctrl_o.reg_write = 1'b1;
          end
        end
      end
      `RV_OP_SYSTEM: begin
        ctrl_o.halt = (insn_i[31:7] == '0);
      end
      default: begin
        // unknown opcode, fence included, leaves all state alone
      end
    endcase
  end

endmodule

// File: hw/rv_lsu.sv
`include "rv_consts.svh"

module rv_lsu (
  input  rv_pkg::ctrl_t     ctrl_i,
  input  rv_pkg::word_t     addr_i,
  input  rv_pkg::word_t     store_data_i,
  input  rv_pkg::word_t     load_data_i,
  output rv_pkg::dmem_req_t dmem_o,
  output rv_pkg::word_t     load_result_o
);

  logic [1:0]  offset;
  logic [7:0]  load_byte;
  logic [15:0] load_half;

  assign offset      = addr_i[1:0];
  assign dmem_o.addr = {addr_i[31:2], 2'b00};

  // store lane placement
  always_comb begin
    dmem_o.wdata   = '0;
    dmem_o.byte_en = '0;
    if (ctrl_i.is_store) begin
      case (ctrl_i.mem_size)
        `RV_MEM_BYTE: begin
          dmem_o.wdata   = {4{store_data_i[7:0]}};
          dmem_o.byte_en = 4'b0001 << offset;
        end
        `RV_MEM_HALF: begin
          dmem_o.wdata = {2{store_data_i[15:0]}};
          if (offset == 2'b00) begin
            dmem_o.byte_en = 4'b0011;
          end else if (offset == 2'b10) begin
            dmem_o.byte_en = 4'b1100;
          end
        end
        default: begin
          dmem_o.wdata = store_data_i;
          if (offset == 2'b00) begin
            dmem_o.byte_en = 4'b1111;
          end
        end
      endcase
    end
  end

  // load lane selection
  always_comb begin
    case (offset)
      2'b00:   load_byte = load_data_i[7:0];
      2'b01:   load_byte = load_data_i[15:8];
      2'b10:   load_byte = load_data_i[23:16];
      default: load_byte = load_data_i[31:24];
    endcase
  end

  assign load_half = offset[1] ? load_data_i[31:16] : load_data_i[15:0];

  always_comb begin
    load_result_o = '0;
    if (ctrl_i.is_load) begin
      case (ctrl_i.mem_size)
        `RV_MEM_BYTE: begin
          load_result_o = {{24{load_byte[7] & ~ctrl_i.load_unsigned}}, load_byte};
        end
        `RV_MEM_HALF: begin
          if (!offset[0]) begin
            load_result_o = {{16{load_half[15] & ~ctrl_i.load_unsigned}}, load_half};
          end
        end
        default: begin
          if (offset == 2'b00) begin
            load_result_o = load_data_i;
          end
        end
      endcase
    end
  end

endmodule

// File: hw/rv_pc_unit.sv
`include "rv_consts.svh"

module rv_pc_unit (
  input  logic          clk_i,
  input  logic          rst_i,
  input  rv_pkg::ctrl_t ctrl_i,
  input  rv_pkg::word_t rs1_data_i,
  input  rv_pkg::word_t rs2_data_i,
  output rv_pkg::word_t pc_o,
  output rv_pkg::word_t pc_plus4_o
);

  rv_pkg::word_t pc_q;
  rv_pkg::word_t pc_next;
  rv_pkg::word_t jalr_target;
  logic          cond;
  logic          taken;

  assign pc_o        = pc_q;
  assign pc_plus4_o  = pc_q + 32'd4;
  assign jalr_target = rs1_data_i + ctrl_i.imm;

  always_comb begin
    case (ctrl_i.branch_f3)
      `RV_F3_BEQ:  cond = (rs1_data_i == rs2_data_i);
      `RV_F3_BNE:  cond = (rs1_data_i != rs2_data_i);
      `RV_F3_BLT:  cond = ($signed(rs1_data_i) < $signed(rs2_data_i));
      `RV_F3_BGE:  cond = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      `RV_F3_BLTU: cond = (rs1_data_i < rs2_data_i);
      `RV_F3_BGEU: cond = (rs1_data_i >= rs2_data_i);
      default:     cond = 1'b0;
    endcase
  end

  assign taken = ctrl_i.is_branch && cond;

  always_comb begin
    if (ctrl_i.is_jalr) begin
      pc_next = {jalr_target[31:1], 1'b0};
    end else if (ctrl_i.is_jal || taken) begin
      pc_next = pc_q + ctrl_i.imm;
    end else begin
      pc_next = pc_plus4_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

endmodule

// File: hw/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  // data word or byte address
  typedef logic [`RV_XLEN-1:0] word_t;

  // register index
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  typedef logic [3:0] alu_op_t;
  typedef logic [1:0] wb_sel_t;
  typedef logic [1:0] mem_size_t;

  // one enable per byte lane of a word
  typedef logic [`RV_XLEN/8-1:0] byte_en_t;

  // decoded control for one instruction
  typedef struct packed {
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_t   alu_op;
    logic      src_b_imm;
    logic      src_a_pc;
    logic      reg_write;
    wb_sel_t   wb_sel;
    logic      is_load;
    logic      is_store;
    mem_size_t mem_size;
    logic      load_unsigned;
    logic      is_branch;
    logic [2:0] branch_f3;
    logic      is_jal;
    logic      is_jalr;
    logic      halt;
  } ctrl_t;

  // data memory request, address always word aligned
  typedef struct packed {
    word_t    addr;
    word_t    wdata;
    byte_en_t byte_en;
  } dmem_req_t;

endpackage

// File: hw/rv_regfile.sv
`include "rv_consts.svh"

module rv_regfile (
  input  logic              clk_i,
  input  logic              rst_i,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              we_i,
  input  rv_pkg::word_t     rd_data_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o
);

  // x0 has no storage
  rv_pkg::word_t regs [1:`RV_NUM_REGS-1];

  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

endmodule

// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// word width and register count
`define RV_XLEN     32
`define RV_NUM_REGS 32

// major opcodes of the kept instructions
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_SYSTEM 7'b1110011

// branch conditions
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// load widths
`define RV_F3_LB  3'b000
`define RV_F3_LH  3'b001
`define RV_F3_LW  3'b010
`define RV_F3_LBU 3'b100
`define RV_F3_LHU 3'b101

// store widths
`define RV_F3_SB 3'b000
`define RV_F3_SH 3'b001
`define RV_F3_SW 3'b010

// arithmetic and logic funct3, shared by reg-reg and reg-imm
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SRL  3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

// funct7 selects sub and sra
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000

// alu operations
`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_SLL    4'd2
`define RV_ALU_SLT    4'd3
`define RV_ALU_SLTU   4'd4
`define RV_ALU_XOR    4'd5
`define RV_ALU_SRL    4'd6
`define RV_ALU_SRA    4'd7
`define RV_ALU_OR     4'd8
`define RV_ALU_AND    4'd9
`define RV_ALU_PASS_B 4'd10

// writeback source
`define RV_WB_ALU  2'd0
`define RV_WB_LOAD 2'd1
`define RV_WB_PC4  2'd2

// memory access size
`define RV_MEM_BYTE 2'd0
`define RV_MEM_HALF 2'd1
`define RV_MEM_WORD 2'd2

`endif

// File: riscv_core.f
+incdir+include
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_pc_unit.sv
hw/riscv_core.sv
bench/riscv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f riscv_core.f --top-module riscv_core_tb \
    -o riscv_core_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/riscv_core_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
